//--- common/cnn_pkg.sv
`default_nettype none

// constants shared by the datapath layers and the testbench reference model
package cnn_pkg;

    // every stream between layers carries signed samples of this width
    localparam int DATA_W = 16;

    localparam int NUM_TAPS = 3; // convolution window length
    localparam int FILL_W = $clog2(NUM_TAPS); // width of the window fill counter

    // three 16-bit samples times the small weights below stay well inside 24 bits
    localparam int ACC_W = 24;

    // tap weights, w0 multiplies the newest sample and w2 the oldest
    localparam logic signed [ACC_W-1:0] CONV_W0 = ACC_W'(3);
    localparam logic signed [ACC_W-1:0] CONV_W1 = ACC_W'(-2);
    localparam logic signed [ACC_W-1:0] CONV_W2 = ACC_W'(5);

    localparam int CONV_SHIFT = 2; // arithmetic right shift before saturation

    // saturation limits of a signed sample
    localparam logic signed [DATA_W-1:0] DATA_MAX = 16'sh7fff;
    localparam logic signed [DATA_W-1:0] DATA_MIN = 16'sh8000;

endpackage

`default_nettype wire

//--- verilog/double_fifo.sv
`timescale 1ns/1ns
`default_nettype none

// two-entry first-word-fall-through FIFO used at each layer boundary
// the head word is always visible on data_o while empty_o is low
// a write into a full FIFO is accepted only in a cycle where it is also read
module double_fifo #(
    parameter int WORD_SIZE = 16
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 wen_i,
    input  wire logic                 ren_i,
    input  wire logic [WORD_SIZE-1:0] data_i,

    output logic                      full_o,
    output logic                      empty_o,
    output logic [WORD_SIZE-1:0]      data_o
);

    // occupancy bit 0 marks the output word, bit 1 the middle word
    logic [1:0] occ_q;
    logic [1:0] occ_d;

    logic [WORD_SIZE-1:0] mid_q; // second entry, waits behind data_o
    logic [WORD_SIZE-1:0] mid_d;
    logic [WORD_SIZE-1:0] out_d;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            occ_q <= 2'b00;
        end else begin
            occ_q <= occ_d;
        end
    end

    // next state and next contents of both words
    always_comb begin
        occ_d = occ_q;
        out_d = data_o;
        mid_d = mid_q;
        case (occ_q)
            2'b00: begin
                // a read is meaningless here, only a write changes anything
                if (wen_i) begin
                    occ_d = 2'b01;
                    out_d = data_i;
                end
            end
            2'b11: begin
                if (ren_i) begin
                    out_d = mid_q; // middle word moves to the head
                    if (wen_i) begin
                        mid_d = data_i;
                    end else begin
                        occ_d = 2'b01;
                    end
                end
            end
            default: begin
                // one word held, 2'b10 cannot be reached and falls back to this case
                occ_d = 2'b01;
                if (wen_i && ren_i) begin
                    out_d = data_i; // head is replaced by the incoming word
                end else if (wen_i) begin
                    occ_d = 2'b11;
                    mid_d = data_i;
                end else if (ren_i) begin
                    occ_d = 2'b00;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        data_o <= out_d;
        mid_q  <= mid_d;
    end

    // full drops in the same cycle as a read so the writer can refill at once
    assign full_o  = (occ_q == 2'b11) && !ren_i;
    assign empty_o = (occ_q == 2'b00);

endmodule

`default_nettype wire

//--- conv/conv1d_layer.sv
`timescale 1ns/1ns
`default_nettype none

// three-tap 1D convolution over a continuous sample stream
// the first NUM_TAPS-1 samples only fill the window and produce no result
module conv1d_layer
    import cnn_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    input  wire logic              src_empty_i,
    output logic                   src_ren_o,
    input  wire logic [DATA_W-1:0] src_data_i,

    input  wire logic              dst_full_i,
    output logic                   dst_wen_o,
    output logic [DATA_W-1:0]      dst_data_o
);

    // window_q[0] is the sample popped last, higher indices are older
    logic signed [DATA_W-1:0] window_q [NUM_TAPS-1];
    logic signed [DATA_W-1:0] taps [NUM_TAPS]; // incoming sample plus the window

    logic [FILL_W-1:0] fill_q; // saturates once the window is complete

    logic              valid_q; // output register holds a result not yet written
    logic [DATA_W-1:0] data_q;

    logic                    pop;
    logic                    load;
    logic signed [ACC_W-1:0] sum;
    logic signed [ACC_W-1:0] shifted;
    logic signed [DATA_W-1:0] sat;

    // the output register is free when empty or drained in this cycle
    assign dst_wen_o = valid_q && !dst_full_i;
    assign pop       = !src_empty_i && (!valid_q || !dst_full_i);
    assign src_ren_o = pop;

    // a pop with a filled window yields a result on the same edge
    assign load = pop && (fill_q >= NUM_TAPS - 1);

    always_comb begin
        taps[0] = src_data_i;
        for (int i = 1; i < NUM_TAPS; i++) begin
            taps[i] = window_q[i-1];
        end
    end

    // weighted sum in the wide accumulator, sign extended before the multiply
    always_comb begin
        sum = ACC_W'(taps[0]) * CONV_W0
            + ACC_W'(taps[1]) * CONV_W1
            + ACC_W'(taps[2]) * CONV_W2;
        shifted = sum >>> CONV_SHIFT;
    end

    // clamp to the signed sample range
    always_comb begin
        if (shifted > ACC_W'(DATA_MAX)) begin
            sat = DATA_MAX;
        end else if (shifted < ACC_W'(DATA_MIN)) begin
            sat = DATA_MIN;
        end else begin
            sat = shifted[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fill_q <= '0;
        end else if (pop && (fill_q < NUM_TAPS - 1)) begin
            fill_q <= fill_q + 1'b1;
        end
    end

    // window shifts by one sample on every pop
    always_ff @(posedge clk_i) begin
        if (pop) begin
            window_q[0] <= src_data_i;
            for (int i = 1; i < NUM_TAPS - 1; i++) begin
                window_q[i] <= window_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1; // a new result replaces one being written
        end else if (dst_wen_o) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= sat;
        end
    end

    assign dst_data_o = data_q;

endmodule

`default_nettype wire

//--- pool/relu_pool_layer.sv
`timescale 1ns/1ns
`default_nettype none

// ReLU followed by max pooling over consecutive pairs of samples
// one result leaves for every two samples taken in
module relu_pool_layer
    import cnn_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    input  wire logic              src_empty_i,
    output logic                   src_ren_o,
    input  wire logic [DATA_W-1:0] src_data_i,

    input  wire logic              dst_full_i,
    output logic                   dst_wen_o,
    output logic [DATA_W-1:0]      dst_data_o
);

    logic              half_q;  // first value of the current pair is held
    logic [DATA_W-1:0] first_q; // clamped first value of the pair

    logic              valid_q;
    logic [DATA_W-1:0] data_q;

    logic              pop;
    logic              load;
    logic [DATA_W-1:0] relu;
    logic [DATA_W-1:0] pair_max;

    assign dst_wen_o = valid_q && !dst_full_i;
    assign pop       = !src_empty_i && (!valid_q || !dst_full_i);
    assign src_ren_o = pop;
    assign load      = pop && half_q; // second value of the pair completes it

    // negative samples clamp to zero, so both operands of the max are non-negative
    assign relu     = src_data_i[DATA_W-1] ? '0 : src_data_i;
    assign pair_max = (relu > first_q) ? relu : first_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            half_q <= 1'b0;
        end else if (pop) begin
            half_q <= !half_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop && !half_q) begin
            first_q <= relu;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (dst_wen_o) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= pair_max;
        end
    end

    assign dst_data_o = data_q;

endmodule

`default_nettype wire

//--- verilog/cnn_stream_top.sv
`timescale 1ns/1ns
`default_nettype none

// streaming datapath: input FIFO, convolution, middle FIFO, pooling, output FIFO
module cnn_stream_top
    import cnn_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    input  wire logic              in_wen_i,
    input  wire logic [DATA_W-1:0] in_data_i,
    output logic                   in_full_o,

    input  wire logic              out_ren_i,
    output logic                   out_empty_o,
    output logic [DATA_W-1:0]      out_data_o
);

    // input FIFO to convolution
    logic              in_empty;
    logic              in_ren;
    logic [DATA_W-1:0] in_head;

    // convolution to middle FIFO and on to pooling
    logic              mid_wen;
    logic [DATA_W-1:0] mid_data;
    logic              mid_full;
    logic              mid_empty;
    logic              mid_ren;
    logic [DATA_W-1:0] mid_head;

    // pooling to output FIFO
    logic              out_wen;
    logic [DATA_W-1:0] out_data;
    logic              out_full;

    double_fifo #(.WORD_SIZE(DATA_W)) fifo_in (
        .clk_i   (clk_i),     .reset_i (reset_i),
        .wen_i   (in_wen_i),  .ren_i   (in_ren),
        .data_i  (in_data_i), .full_o  (in_full_o),
        .empty_o (in_empty),  .data_o  (in_head)
    );

    conv1d_layer conv (
        .clk_i       (clk_i),    .reset_i    (reset_i),
        .src_empty_i (in_empty), .src_ren_o  (in_ren),    .src_data_i (in_head),
        .dst_full_i  (mid_full), .dst_wen_o  (mid_wen),   .dst_data_o (mid_data)
    );

    double_fifo #(.WORD_SIZE(DATA_W)) fifo_mid (
        .clk_i   (clk_i),     .reset_i (reset_i),
        .wen_i   (mid_wen),   .ren_i   (mid_ren),
        .data_i  (mid_data),  .full_o  (mid_full),
        .empty_o (mid_empty), .data_o  (mid_head)
    );

    relu_pool_layer pool (
        .clk_i       (clk_i),     .reset_i    (reset_i),
        .src_empty_i (mid_empty), .src_ren_o  (mid_ren),  .src_data_i (mid_head),
        .dst_full_i  (out_full),  .dst_wen_o  (out_wen),  .dst_data_o (out_data)
    );

    double_fifo #(.WORD_SIZE(DATA_W)) fifo_out (
        .clk_i   (clk_i),       .reset_i (reset_i),
        .wen_i   (out_wen),     .ren_i   (out_ren_i),
        .data_i  (out_data),    .full_o  (out_full),
        .empty_o (out_empty_o), .data_o  (out_data_o)
    );

endmodule

`default_nettype wire

//--- verif/cnn_stream_assertions.sv
`timescale 1ns/1ns
`default_nettype none

// handshake rules that every double_fifo boundary of the datapath must keep
// bound into each FIFO instance from the testbench
module cnn_stream_assertions (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic wen_i,
    input wire logic ren_i,
    input wire logic full_i,
    input wire logic empty_i
);

    // a writer waits while the FIFO reports full since a full FIFO would drop the word
    write_guard: assert property (
        @(posedge clk_i) disable iff (reset_i) full_i |-> !wen_i
    ) else $error("write into a full FIFO");

    // the head word is only valid while empty is low
    read_guard: assert property (
        @(posedge clk_i) disable iff (reset_i) empty_i |-> !ren_i
    ) else $error("read from an empty FIFO");

    // an accepted write always leaves at least one word behind
    write_lands: assert property (
        @(posedge clk_i) disable iff (reset_i) wen_i |=> !empty_i
    ) else $error("written word lost, FIFO empty after a write");

endmodule

`default_nettype wire

//--- verif/cnn_stream_tb.sv
`timescale 1ns/1ns
`default_nettype none

// testbench for the streaming convolution and pooling datapath
module cnn_stream_tb
    import cnn_pkg::*;
;

    localparam logic [31:0] SEED = 32'd64455;

    logic              clk_i     = 1'b0;
    logic              reset_i   = 1'b1;
    logic              in_wen_i  = 1'b0;
    logic [DATA_W-1:0] in_data_i = '0;
    logic              out_ren_i = 1'b0;
    logic              in_full_o;
    logic              out_empty_o;
    logic [DATA_W-1:0] out_data_o;

    logic signed [DATA_W-1:0] samples [$]; // every sample handed to the writer so far

    int wr_idx   = 0; // next sample to write
    int rd_count = 0; // outputs popped and compared so far
    int wr_rate  = 0; // write chance out of 256, zero stops the writer
    int rd_rate  = 0; // read chance out of 256, zero stops the reader

    logic [31:0] gen_rng = SEED;
    logic [31:0] wr_rng  = SEED + 32'd1;
    logic [31:0] rd_rng  = SEED + 32'd2;

    cnn_stream_top uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_wen_i    (in_wen_i),
        .in_data_i   (in_data_i),
        .in_full_o   (in_full_o),
        .out_ren_i   (out_ren_i),
        .out_empty_o (out_empty_o),
        .out_data_o  (out_data_o)
    );

    bind double_fifo cnn_stream_assertions fifo_checks (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wen_i   (wen_i),
        .ren_i   (ren_i),
        .full_i  (full_o),
        .empty_i (empty_o)
    );

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // uniform value in base .. base+spread-1 from the stimulus generator
    function automatic logic signed [DATA_W-1:0] next_sample(input int base, input int spread);
        gen_rng = lcg_next(gen_rng);
        return DATA_W'(base + int'(gen_rng[30:16]) % spread);
    endfunction

    // number of complete pairs of convolution results
    // the first two samples only fill the window
    function automatic int expected_count();
        return (samples.size() < 2) ? 0 : (samples.size() - 2) / 2;
    endfunction

    // output k pools the convolutions at window starts 2k and 2k+1
    function automatic logic [DATA_W-1:0] expected_at(input int k);
        int acc;
        int best;
        int j;
        best = 0; // zero is the relu floor and thus the smallest possible result
        for (int p = 0; p < 2; p++) begin
            j = 2 * k + p;
            acc = int'(CONV_W0) * int'(samples[j+2])
                + int'(CONV_W1) * int'(samples[j+1])
                + int'(CONV_W2) * int'(samples[j]);
            acc = acc >>> CONV_SHIFT;
            if (acc > int'(DATA_MAX)) begin
                acc = int'(DATA_MAX);
            end else if (acc < int'(DATA_MIN)) begin
                acc = int'(DATA_MIN);
            end
            if (acc > best) begin
                best = acc;
            end
        end
        return DATA_W'(best);
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure("value mismatch");
        end
    endtask

    task automatic wait_for_outputs(input string what, input int limit);
        int cycles;
        cycles = 0;
        while (rd_count != expected_count()) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > limit) begin
                stop_with_failure({"timed out waiting for ", what});
            end
        end
    endtask

    task automatic wait_for_input_full(input int limit);
        int cycles;
        cycles = 0;
        while (!in_full_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > limit) begin
                stop_with_failure("timed out waiting for in_full_o to rise under back-pressure");
            end
        end
    endtask

    // a write needs one idle cycle after it before full reflects it again
    always @(posedge clk_i) begin
        if (reset_i || in_wen_i) begin
            in_wen_i <= 1'b0;
        end else if (!in_full_o && wr_idx < samples.size() && wr_rate > 0) begin
            wr_rng = lcg_next(wr_rng);
            if (int'(wr_rng[23:16]) < wr_rate) begin
                in_wen_i  <= 1'b1;
                in_data_i <= samples[wr_idx];
                wr_idx    <= wr_idx + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        if (reset_i || out_ren_i) begin
            out_ren_i <= 1'b0; // empty flag of the last read is not visible yet
        end else if (!out_empty_o && rd_rate > 0) begin
            rd_rng = lcg_next(rd_rng);
            if (int'(rd_rng[23:16]) < rd_rate) begin
                out_ren_i <= 1'b1;
            end
        end
    end

    // every popped word is compared with the next reference value
    always @(posedge clk_i) begin
        if (!reset_i && out_ren_i && !out_empty_o) begin
            if (rd_count >= expected_count()) begin
                stop_with_failure("an output arrived beyond the expected count");
            end else begin
                check_value("out_data_o", 32'(out_data_o), 32'(expected_at(rd_count)));
                rd_count <= rd_count + 1;
            end
        end
    end

    initial begin
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;

        // idle datapath after reset
        repeat (20) begin
            @(negedge clk_i);
            check_value("out_empty_o", 32'(out_empty_o), 32'd1);
            check_value("in_full_o", 32'(in_full_o), 32'd0);
        end

        // continuous stream with reading always allowed
        wr_rate = 256;
        rd_rate = 256;
        repeat (40) samples.push_back(next_sample(-2048, 4096));
        wait_for_outputs("the outputs of the continuous stream", 1000);

        // with the reader held off any surplus word stays visible at the output
        rd_rate = 0;
        repeat (20) @(negedge clk_i);
        check_value("out_empty_o", 32'(out_empty_o), 32'd1);

        // reader stalled until the back-pressure reaches the input
        repeat (30) samples.push_back(next_sample(-2048, 4096));
        wait_for_input_full(500);
        repeat (10) @(negedge clk_i);
        rd_rate = 256;
        wait_for_outputs("the outputs held back by back-pressure", 1000);

        // random gaps on both sides
        wr_rate = 128;
        rd_rate = 100;
        repeat (60) samples.push_back(next_sample(-2048, 4096));
        wait_for_outputs("the outputs of the random-gap stream", 3000);

        // saturating sums and negative stretches that relu clamps to zero
        wr_rate = 256;
        rd_rate = 256;
        repeat (12) samples.push_back(next_sample(32767 - 511, 512));
        repeat (12) samples.push_back(next_sample(-32768, 512));
        for (int i = 0; i < 10; i++) begin
            samples.push_back(next_sample((i % 2 == 0) ? 31900 : -32100, 200));
        end
        wait_for_outputs("the outputs of the saturation stream", 1000);
        repeat (20) @(negedge clk_i);

        if (rd_count == expected_count()) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stop_with_failure("final output count differs from the reference");
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
common/cnn_pkg.sv
verilog/double_fifo.sv
conv/conv1d_layer.sv
pool/relu_pool_layer.sv
verilog/cnn_stream_top.sv
verif/cnn_stream_assertions.sv
verif/cnn_stream_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the datapath testbench with Verilator and run it.
# The run fails when the log holds the fail message or lacks the pass message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module cnn_stream_tb -f vlog.f -o sim_cnn_stream

./obj_dir/sim_cnn_stream > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
